// File: all.f
hw/chipset_pkg.sv
hw/mem_bus_if.sv
hw/reg_bus_if.sv
hw/bus_arbiter.sv
hw/chip_ram.sv
hw/cpu_bridge.sv
hw/copy_engine.sv
hw/int_ctrl.sv
hw/chipset_top.sv
sim/bus_checker.sv
sim/tb_top.sv

// File: hw/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import chipset_pkg::*; (
	input logic clk,
	input logic reset,
	mem_bus_if.arbiter cpu_m,
	mem_bus_if.arbiter dma_m,
	output logic ram_we_o,
	output logic [RAM_AW-1:0] ram_addr_o,
	output word_t ram_wdata_o,
	input word_t ram_rdata_i
);

	logic cpu_gnt;
	logic dma_gnt;
	logic last_dma_q;	// dma won the last granted cycle
	logic rd_pend_q;	// read data arrives from ram this cycle
	logic rd_dma_q;	// owner of that read

	// ------------------------------------------------------------
	// grant, dma first but alternate under contention
	// ------------------------------------------------------------
	assign dma_gnt = dma_m.req_valid & (~cpu_m.req_valid | ~last_dma_q);
	assign cpu_gnt = cpu_m.req_valid & ~dma_gnt;

	assign cpu_m.req_ready = cpu_gnt;
	assign dma_m.req_ready = dma_gnt;

	// ram port mux
	assign ram_we_o = dma_gnt ? dma_m.req_we : (cpu_gnt & cpu_m.req_we);
	assign ram_addr_o = dma_gnt ? dma_m.req_addr : cpu_m.req_addr;
	assign ram_wdata_o = dma_gnt ? dma_m.req_wdata : cpu_m.req_wdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			last_dma_q <= 1'b0;
			rd_pend_q <= 1'b0;
			rd_dma_q <= 1'b0;
		end else begin
			if (cpu_gnt || dma_gnt)
				last_dma_q <= dma_gnt;	// idle cycles keep the history
			rd_pend_q <= (cpu_gnt & ~cpu_m.req_we) | (dma_gnt & ~dma_m.req_we);
			rd_dma_q <= dma_gnt;
		end
	end

	// ------------------------------------------------------------
	// read response routing
	// ------------------------------------------------------------
	assign cpu_m.rsp_valid = rd_pend_q & ~rd_dma_q;
	assign dma_m.rsp_valid = rd_pend_q & rd_dma_q;
	assign cpu_m.rsp_rdata = ram_rdata_i;	// qualified by rsp_valid
	assign dma_m.rsp_rdata = ram_rdata_i;

endmodule

// File: hw/chip_ram.sv
`timescale 1ns/1ps

module chip_ram import chipset_pkg::*; (
	input logic clk,
	input logic we_i,
	input logic [RAM_AW-1:0] addr_i,
	input word_t wdata_i,
	output word_t rdata_o
);

	word_t mem [RAM_WORDS];

	// single port, read every cycle
	always_ff @(posedge clk) begin
		if (we_i)
			mem[addr_i] <= wdata_i;
		rdata_o <= mem[addr_i];	// old data on a write, nobody looks
	end

endmodule

// File: hw/chipset_pkg.sv
package chipset_pkg;

	// ------------------------------------------------------------
	// sizes and address map
	// ------------------------------------------------------------
	localparam int DATA_W = 16;	// one bus word
	localparam int ADDR_W = 16;	// cpu word address
	localparam int RAM_AW = 10;	// chip ram index
	localparam int RAM_WORDS = 1 << RAM_AW;	// 1k words
	localparam int REG_AW = 5;	// custom register index

	// top two address bits pick the region, 2 and 3 are unmapped
	localparam logic [1:0] REGION_RAM = 2'd0;
	localparam logic [1:0] REGION_REG = 2'd1;

	// custom register indexes
	localparam logic [REG_AW-1:0] REG_BLTSRC = 5'd0;	// copy source index
	localparam logic [REG_AW-1:0] REG_BLTDST = 5'd1;	// copy destination index
	localparam logic [REG_AW-1:0] REG_BLTLEN = 5'd2;	// word count, write starts copy
	localparam logic [REG_AW-1:0] REG_INTENA = 5'd3;
	localparam logic [REG_AW-1:0] REG_INTREQ = 5'd4;
	localparam logic [REG_AW-1:0] REG_STATUS = 5'd5;	// bit 0 copy busy

	// interrupt bits and levels
	localparam int INT_SOFT = 0;
	localparam int INT_BLIT = 1;
	localparam int INT_EXT = 2;
	localparam int INT_MASTER = 14;	// enable only
	localparam int INT_SETCLR = 15;	// 1 sets, 0 clears the written ones
	localparam logic [2:0] IPL_SOFT = 3'd1;
	localparam logic [2:0] IPL_BLIT = 3'd3;
	localparam logic [2:0] IPL_EXT = 3'd6;

	// bridge fsm states
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_RAM = 2'd1;	// waiting on the chip ram bus
	localparam logic [1:0] ST_RESP = 2'd2;

	typedef logic [DATA_W-1:0] word_t;

	// same cpu address seen as ram access or as register access
	typedef union packed {
		struct packed {
			logic [1:0] region;
			logic [ADDR_W-RAM_AW-3:0] pad;	// ram mirrors across these
			logic [RAM_AW-1:0] idx;
		} ram;
		struct packed {
			logic [1:0] region;
			logic [ADDR_W-REG_AW-3:0] pad;
			logic [REG_AW-1:0] idx;
		} regs;
	} cpu_addr_u;

endpackage

// File: hw/chipset_top.sv
`timescale 1ns/1ps

module chipset_top import chipset_pkg::*; (
	input logic clk,
	input logic reset,
	input logic cpu_valid_i,
	input logic cpu_we_i,
	input logic [ADDR_W-1:0] cpu_addr_i,
	input word_t cpu_wdata_i,
	input logic ext_int_i,
	output logic cpu_ready_o,
	output logic cpu_rsp_valid_o,
	output word_t cpu_rdata_o,
	output logic [2:0] cpu_ipl_o,
	output logic copy_busy_o
);

	// ------------------------------------------------------------
	// buses and wires
	// ------------------------------------------------------------
	mem_bus_if cpu_mem ();	// bridge to arbiter
	mem_bus_if dma_mem ();	// copy engine to arbiter
	reg_bus_if regs_bus ();

	logic blit_done;
	logic ram_we;
	logic [RAM_AW-1:0] ram_addr;
	word_t ram_wdata;
	word_t ram_rdata;

	// register read data from all peers
	assign regs_bus.rdata = regs_bus.rdata_dma | regs_bus.rdata_int;

	cpu_bridge u_bridge (
		.clk(clk),
		.reset(reset),
		.cpu_valid_i(cpu_valid_i),
		.cpu_we_i(cpu_we_i),
		.cpu_addr_i(cpu_addr_i),
		.cpu_wdata_i(cpu_wdata_i),
		.cpu_ready_o(cpu_ready_o),
		.cpu_rsp_valid_o(cpu_rsp_valid_o),
		.cpu_rdata_o(cpu_rdata_o),
		.mem(cpu_mem),
		.regs(regs_bus)
	);

	copy_engine u_copy (
		.clk(clk),
		.reset(reset),
		.regs(regs_bus),
		.mem(dma_mem),
		.busy_o(copy_busy_o),
		.blit_done_o(blit_done)
	);

	int_ctrl u_int (
		.clk(clk),
		.reset(reset),
		.regs(regs_bus),
		.blit_done_i(blit_done),
		.ext_int_i(ext_int_i),
		.ipl_o(cpu_ipl_o)
	);

	bus_arbiter u_arb (
		.clk(clk),
		.reset(reset),
		.cpu_m(cpu_mem),
		.dma_m(dma_mem),
		.ram_we_o(ram_we),
		.ram_addr_o(ram_addr),
		.ram_wdata_o(ram_wdata),
		.ram_rdata_i(ram_rdata)
	);

	chip_ram u_ram (
		.clk(clk),
		.we_i(ram_we),
		.addr_i(ram_addr),
		.wdata_i(ram_wdata),
		.rdata_o(ram_rdata)
	);

endmodule

// File: hw/copy_engine.sv
`timescale 1ns/1ps

module copy_engine import chipset_pkg::*; (
	input logic clk,
	input logic reset,
	reg_bus_if.peer_dma regs,
	mem_bus_if.master mem,
	output logic busy_o,
	output logic blit_done_o
);

	logic [RAM_AW-1:0] src_q;
	logic [RAM_AW-1:0] dst_q;
	word_t cnt_q;	// words left
	logic busy_q;
	logic wr_phase_q;	// 0 read, 1 write
	logic rd_sent_q;	// read granted, waiting for data
	logic done_q;
	word_t data_q;	// word in transit
	logic wr_en;
	logic wr_xfer;

	// registers frozen while a copy runs, BLTLEN write then ignored too
	assign wr_en = regs.we & ~busy_q;
	assign wr_xfer = mem.req_valid & mem.req_ready & wr_phase_q;

	// ------------------------------------------------------------
	// dma master side
	// ------------------------------------------------------------
	assign mem.req_valid = busy_q & (wr_phase_q | ~rd_sent_q);
	assign mem.req_we = wr_phase_q;
	assign mem.req_addr = wr_phase_q ? dst_q : src_q;
	assign mem.req_wdata = data_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			src_q <= '0;
			dst_q <= '0;
			cnt_q <= '0;
			busy_q <= 1'b0;
			wr_phase_q <= 1'b0;
			rd_sent_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (wr_en && regs.idx == REG_BLTSRC)
				src_q <= regs.wdata[RAM_AW-1:0];
			if (wr_en && regs.idx == REG_BLTDST)
				dst_q <= regs.wdata[RAM_AW-1:0];
			if (wr_en && regs.idx == REG_BLTLEN) begin
				cnt_q <= regs.wdata;
				busy_q <= |regs.wdata;	// zero length never starts
				wr_phase_q <= 1'b0;
				rd_sent_q <= 1'b0;
			end
			if (busy_q && !wr_phase_q) begin
				if (mem.req_valid && mem.req_ready)
					rd_sent_q <= 1'b1;
				if (mem.rsp_valid) begin
					rd_sent_q <= 1'b0;
					wr_phase_q <= 1'b1;
					src_q <= src_q + 1'b1;	// wraps at ram size
				end
			end
			if (wr_xfer) begin
				wr_phase_q <= 1'b0;
				dst_q <= dst_q + 1'b1;
				cnt_q <= cnt_q - 1'b1;
				if (cnt_q == 16'd1) begin
					busy_q <= 1'b0;	// last word written
					done_q <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (mem.rsp_valid)
			data_q <= mem.rsp_rdata;
	end

	// register reads, zero for foreign indexes
	always_comb begin
		regs.rdata_dma = '0;
		if (regs.re) begin
			case (regs.idx)
				REG_BLTSRC: regs.rdata_dma = word_t'(src_q);
				REG_BLTDST: regs.rdata_dma = word_t'(dst_q);
				REG_BLTLEN: regs.rdata_dma = cnt_q;
				REG_STATUS: regs.rdata_dma = word_t'(busy_q);
				default: regs.rdata_dma = '0;
			endcase
		end
	end

	assign busy_o = busy_q;
	assign blit_done_o = done_q;

endmodule

// File: hw/cpu_bridge.sv
`timescale 1ns/1ps

module cpu_bridge import chipset_pkg::*; (
	input logic clk,
	input logic reset,
	input logic cpu_valid_i,
	input logic cpu_we_i,
	input logic [ADDR_W-1:0] cpu_addr_i,
	input word_t cpu_wdata_i,
	output logic cpu_ready_o,
	output logic cpu_rsp_valid_o,
	output word_t cpu_rdata_o,
	mem_bus_if.master mem,
	reg_bus_if.bridge regs
);

	logic [1:0] state_q;
	logic sent_q;	// ram read issued, data pending
	logic we_q;
	cpu_addr_u addr_in;
	cpu_addr_u addr_q;
	word_t wdata_q;
	word_t rdata_q;	// ram read data held for the response
	logic accept;
	logic is_ram;
	logic is_reg;

	assign addr_in = cpu_addr_i;
	assign cpu_ready_o = state_q == ST_IDLE;	// one request outstanding
	assign accept = cpu_valid_i & cpu_ready_o;

	// decode of the latched address
	assign is_ram = addr_q.ram.region == REGION_RAM;
	assign is_reg = addr_q.regs.region == REGION_REG;

	// ------------------------------------------------------------
	// chip ram request
	// ------------------------------------------------------------
	assign mem.req_valid = (state_q == ST_RAM) & ~sent_q;
	assign mem.req_we = we_q;
	assign mem.req_addr = addr_q.ram.idx;	// pad bits dropped
	assign mem.req_wdata = wdata_q;

	// register strobe in the response cycle
	assign regs.re = (state_q == ST_RESP) & is_reg & ~we_q;
	assign regs.we = (state_q == ST_RESP) & is_reg & we_q;
	assign regs.idx = addr_q.regs.idx;
	assign regs.wdata = wdata_q;

	assign cpu_rsp_valid_o = state_q == ST_RESP;

	always_comb begin
		cpu_rdata_o = '0;	// writes and unmapped space answer zero
		if (state_q == ST_RESP && !we_q) begin
			if (is_ram)
				cpu_rdata_o = rdata_q;
			else if (is_reg)
				cpu_rdata_o = regs.rdata;	// combinational from the peers
		end
	end

	// ------------------------------------------------------------
	// fsm
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= ST_IDLE;
			sent_q <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (accept)
						state_q <= (addr_in.ram.region == REGION_RAM) ? ST_RAM : ST_RESP;
				end
				ST_RAM: begin
					if (mem.req_valid && mem.req_ready) begin
						if (we_q)
							state_q <= ST_RESP;	// writes done on grant
						else
							sent_q <= 1'b1;
					end
					if (mem.rsp_valid) begin
						sent_q <= 1'b0;
						state_q <= ST_RESP;
					end
				end
				default: state_q <= ST_IDLE;	// response lasts one cycle
			endcase
		end
	end

	// request and read data holding
	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q <= addr_in;
			we_q <= cpu_we_i;
			wdata_q <= cpu_wdata_i;
		end
		if (mem.rsp_valid)
			rdata_q <= mem.rsp_rdata;
	end

endmodule

// File: hw/int_ctrl.sv
`timescale 1ns/1ps

module int_ctrl import chipset_pkg::*; (
	input logic clk,
	input logic reset,
	reg_bus_if.peer_int regs,
	input logic blit_done_i,
	input logic ext_int_i,
	output logic [2:0] ipl_o
);

	word_t intena_q;
	word_t intreq_q;
	word_t hw_set;	// request bits raised by hardware
	word_t active;
	logic ext_q;

	// amiga style write, bit 15 picks set or clear
	function automatic word_t set_clr(input word_t cur, input word_t wr);
		word_t nxt;
		if (wr[INT_SETCLR])
			nxt = cur | wr;
		else
			nxt = cur & ~wr;
		nxt[INT_SETCLR] = 1'b0;	// never stored
		return nxt;
	endfunction

	always_comb begin
		hw_set = '0;
		hw_set[INT_BLIT] = blit_done_i;
		hw_set[INT_EXT] = ext_int_i & ~ext_q;	// rising edge only
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			intena_q <= '0;
			intreq_q <= '0;
			ext_q <= 1'b0;
		end else begin
			ext_q <= ext_int_i;
			if (regs.we && regs.idx == REG_INTENA)
				intena_q <= set_clr(intena_q, regs.wdata);
			// hardware set wins over a clear in the same cycle
			if (regs.we && regs.idx == REG_INTREQ)
				intreq_q <= set_clr(intreq_q, regs.wdata) | hw_set;
			else
				intreq_q <= intreq_q | hw_set;
		end
	end

	// ------------------------------------------------------------
	// priority encoder, highest level wins
	// ------------------------------------------------------------
	assign active = intreq_q & intena_q;

	always_comb begin
		ipl_o = 3'd0;
		if (intena_q[INT_MASTER]) begin
			if (active[INT_EXT])
				ipl_o = IPL_EXT;
			else if (active[INT_BLIT])
				ipl_o = IPL_BLIT;
			else if (active[INT_SOFT])
				ipl_o = IPL_SOFT;
		end
	end

	assign regs.rdata_int = !regs.re ? '0 :
		(regs.idx == REG_INTENA) ? intena_q :
		(regs.idx == REG_INTREQ) ? intreq_q : '0;

endmodule

// File: hw/mem_bus_if.sv
`timescale 1ns/1ps

// one master's path to chip ram
interface mem_bus_if import chipset_pkg::*; ();

	logic req_valid;
	logic req_ready;	// grant, combinational
	logic req_we;
	logic [RAM_AW-1:0] req_addr;
	word_t req_wdata;
	logic rsp_valid;	// one cycle after a granted read
	word_t rsp_rdata;

	modport master (
		output req_valid, req_we, req_addr, req_wdata,
		input req_ready, rsp_valid, rsp_rdata
	);

	modport arbiter (
		input req_valid, req_we, req_addr, req_wdata,
		output req_ready, rsp_valid, rsp_rdata
	);

endinterface

// File: hw/reg_bus_if.sv
`timescale 1ns/1ps

// custom register strobe, bridge to the register peers
interface reg_bus_if import chipset_pkg::*; ();

	logic re;	// one cycle strobes
	logic we;
	logic [REG_AW-1:0] idx;
	word_t wdata;
	word_t rdata;	// merged read data seen by the bridge
	word_t rdata_dma;	// copy engine share, zero when not its index
	word_t rdata_int;	// interrupt controller share

	modport bridge (output re, we, idx, wdata, input rdata);
	modport peer_dma (input re, we, idx, wdata, output rdata_dma);
	modport peer_int (input re, we, idx, wdata, output rdata_int);

endinterface

// File: run.sh
#!/bin/sh
# build with verilator and run, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f all.f --top-module tb_top -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" \
	&& echo "run passed" \
	|| { echo "run failed"; exit 1; }

// File: sim/bus_checker.sv
`timescale 1ns/1ps

module bus_checker import chipset_pkg::*; (
	input logic clk,
	input logic reset,
	input logic cpu_valid_i,
	input logic cpu_we_i,
	input logic [ADDR_W-1:0] cpu_addr_i,
	input word_t cpu_wdata_i,
	input logic ext_int_i,
	input logic cpu_ready_o,
	input logic cpu_rsp_valid_o,
	input word_t cpu_rdata_o,
	input logic [2:0] cpu_ipl_o,
	input logic copy_busy_o,
	input logic end_i,	// run over, nothing may be pending
	output int err_cnt_o
);

	word_t ram_m [RAM_WORDS];
	logic ram_ok [RAM_WORDS];	// word holds a known value
	logic [RAM_AW-1:0] src_m;
	logic [RAM_AW-1:0] dst_m;
	word_t len_m;
	word_t intena_m;
	word_t intreq_m;
	logic busy_d;
	logic ext_d;
	logic busy_due;	// copy must show busy this cycle
	int busy_lim;	// longest copy allowed, in cycles
	int busy_cyc;
	int cyc;
	int errors;
	logic q_we [$];	// accepted requests, oldest first
	logic [ADDR_W-1:0] q_addr [$];
	word_t q_wdata [$];
	int q_cyc [$];

	assign err_cnt_o = errors;

	initial begin
		errors = 0;
		cyc = 0;
		for (int i = 0; i < RAM_WORDS; i++)
			ram_ok[i] = 1'b0;
	end

	// ------------------------------------------------------------
	// reference rules
	// ------------------------------------------------------------
	function automatic word_t set_clr_ref(input word_t cur, input word_t wr);
		word_t mask;
		mask = wr & 16'h7fff;	// bit 15 only selects the mode
		if (wr[15])
			return cur | mask;
		return cur & ~mask;
	endfunction

	function automatic logic [2:0] level_ref(input word_t ena, input word_t req);
		if (!ena[14])
			return 3'd0;	// master enable off
		if (ena[2] && req[2])
			return 3'd6;
		if (ena[1] && req[1])
			return 3'd3;
		if (ena[0] && req[0])
			return 3'd1;
		return 3'd0;
	endfunction

	task automatic model_copy(input word_t len);
		for (int i = 0; i < int'(len); i++) begin
			ram_m[dst_m] = ram_m[src_m];
			ram_ok[dst_m] = ram_ok[src_m];
			src_m = src_m + 1'b1;	// both wrap at ram size
			dst_m = dst_m + 1'b1;
		end
	endtask

	// ------------------------------------------------------------
	// request log and response compare
	// ------------------------------------------------------------
	always @(posedge clk) begin
		logic we;
		logic [ADDR_W-1:0] addr;
		word_t wd;
		int acc;
		word_t exp;
		logic known;
		word_t hw;
		cyc = cyc + 1;
		if (reset) begin
			intena_m = '0;
			intreq_m = '0;
			src_m = '0;
			dst_m = '0;
			len_m = '0;
			busy_d = 1'b0;
			ext_d = 1'b0;
			busy_due = 1'b0;
			busy_lim = 0;
			busy_cyc = 0;
			q_we.delete();
			q_addr.delete();
			q_wdata.delete();
			q_cyc.delete();
		end else begin
			hw = '0;
			hw[1] = busy_d & ~copy_busy_o;	// copy just ended
			hw[2] = ext_int_i & ~ext_d;	// rising edge
			if (copy_busy_o && !busy_d && !busy_due) begin
				errors++;
				$display("time %0t: copy_busy_o rose without a copy being started", $time);
			end
			if (busy_due && !copy_busy_o) begin
				errors++;
				$display("CHECK FAILED time=%0t signal=copy_busy_o expected=1 actual=0",
					$time);
			end
			busy_due = 1'b0;
			busy_cyc = copy_busy_o ? busy_cyc + 1 : 0;
			if (busy_cyc == busy_lim + 1) begin
				errors++;
				$display("time %0t: copy still busy after %0d cycles", $time, busy_lim);
			end
			busy_d = copy_busy_o;
			ext_d = ext_int_i;
			if (q_we.size() != 0 && cpu_ready_o) begin
				errors++;
				$display("time %0t: cpu_ready_o high while a request is outstanding", $time);
			end
			if (cpu_rsp_valid_o) begin
				if (q_we.size() == 0) begin
					errors++;
					$display("time %0t: response seen without an accepted request", $time);
				end else begin
					we = q_we.pop_front();
					addr = q_addr.pop_front();
					wd = q_wdata.pop_front();
					acc = q_cyc.pop_front();
					exp = '0;	// writes and unmapped space
					known = 1'b1;
					if (addr[15:14] != 2'd0 && cyc != acc + 1) begin
						errors++;
						$display("time %0t: response after %0d cycles, not 1", $time, cyc - acc);
					end
					if (addr[15:14] == 2'd0) begin
						if (we) begin
							ram_m[addr[9:0]] = wd;
							ram_ok[addr[9:0]] = 1'b1;
						end else begin
							exp = ram_m[addr[9:0]];
							known = ram_ok[addr[9:0]];	// never written, skip
						end
					end else if (addr[15:14] == 2'd1) begin
						if (!we) begin
							case (addr[4:0])
								5'd0: exp = word_t'(src_m);
								5'd1: exp = word_t'(dst_m);
								5'd2: exp = len_m;
								5'd3: exp = intena_m;
								5'd4: exp = intreq_m;
								5'd5: exp = word_t'(copy_busy_o);
								default: exp = '0;
							endcase
						end else begin
							case (addr[4:0])
								5'd0: if (!copy_busy_o) src_m = wd[9:0];
								5'd1: if (!copy_busy_o) dst_m = wd[9:0];
								5'd2: if (!copy_busy_o) begin
									model_copy(wd);	// whole copy lands at once
									len_m = '0;
									busy_due = wd != '0;	// zero length starts nothing
									busy_lim = int'(wd) * 5 + 4;	// cpu wins one cycle in three
									busy_cyc = 0;
								end
								5'd3: intena_m = set_clr_ref(intena_m, wd);
								5'd4: intreq_m = set_clr_ref(intreq_m, wd);
								default: ;
							endcase
						end
					end
					if (known && cpu_rdata_o !== exp) begin
						errors++;
						$display("CHECK FAILED time=%0t signal=cpu_rdata_o expected=%h actual=%h",
							$time, exp, cpu_rdata_o);
					end
				end
			end
			intreq_m = intreq_m | hw;	// hardware set beats a clear
			if (cpu_valid_i && cpu_ready_o) begin
				q_we.push_back(cpu_we_i);
				q_addr.push_back(cpu_addr_i);
				q_wdata.push_back(cpu_wdata_i);
				q_cyc.push_back(cyc);
			end
			if (end_i && q_we.size() != 0) begin
				errors++;
				$display("time %0t: %0d requests never got a response", $time, q_we.size());
				q_we.delete();
				q_addr.delete();
				q_wdata.delete();
				q_cyc.delete();
			end
		end
	end

	// level checked mid cycle, blit bit may lag while copying
	always @(negedge clk) begin
		logic [2:0] lvl;
		logic [2:0] alt;
		if (!reset) begin
			lvl = level_ref(intena_m, intreq_m);
			alt = level_ref(intena_m, intreq_m ^ 16'h0002);
			if (cpu_ipl_o !== lvl && !(copy_busy_o && cpu_ipl_o === alt)) begin
				errors++;
				$display("CHECK FAILED time=%0t signal=cpu_ipl_o expected=%0d actual=%0d",
					$time, lvl, cpu_ipl_o);
			end
		end
	end

endmodule

// File: sim/tb_top.sv
`timescale 1ns/1ps

module tb_top import chipset_pkg::*; ();

	localparam int MAX_ACC = 400;	// upper bound on test accesses
	localparam int MAX_LEN = 16;
	localparam int TIMEOUT_CYC = MAX_ACC * (MAX_LEN * 4 + 4) + 1000;

	logic clk = 1'b0;
	logic reset;
	logic cpu_valid;
	logic cpu_we;
	logic [ADDR_W-1:0] cpu_addr;
	word_t cpu_wdata;
	logic ext_int;
	logic cpu_ready;
	logic cpu_rsp_valid;
	word_t cpu_rdata;
	logic [2:0] cpu_ipl;
	logic copy_busy;
	logic end_chk;
	int err_cnt;
	int cycles = 0;
	int n_acc = 0;

	always #5 clk = ~clk;

	chipset_top dut_i (
		.clk(clk), .reset(reset),
		.cpu_valid_i(cpu_valid), .cpu_we_i(cpu_we),
		.cpu_addr_i(cpu_addr), .cpu_wdata_i(cpu_wdata),
		.ext_int_i(ext_int), .cpu_ready_o(cpu_ready),
		.cpu_rsp_valid_o(cpu_rsp_valid), .cpu_rdata_o(cpu_rdata),
		.cpu_ipl_o(cpu_ipl), .copy_busy_o(copy_busy)
	);

	bus_checker checker_i (
		.clk(clk), .reset(reset),
		.cpu_valid_i(cpu_valid), .cpu_we_i(cpu_we),
		.cpu_addr_i(cpu_addr), .cpu_wdata_i(cpu_wdata),
		.ext_int_i(ext_int), .cpu_ready_o(cpu_ready),
		.cpu_rsp_valid_o(cpu_rsp_valid), .cpu_rdata_o(cpu_rdata),
		.cpu_ipl_o(cpu_ipl), .copy_busy_o(copy_busy),
		.end_i(end_chk), .err_cnt_o(err_cnt)
	);

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYC) begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycles);
			$display("errors: %0d plus the timeout", err_cnt);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// stimulus tasks, all start and end on a rising edge
	// ------------------------------------------------------------
	function automatic logic [ADDR_W-1:0] ram_addr(input logic [RAM_AW-1:0] idx);
		return {2'd0, 4'($urandom), idx};	// random pad, same ram word
	endfunction

	function automatic logic [ADDR_W-1:0] reg_addr(input logic [REG_AW-1:0] idx);
		return {2'd1, 9'd0, idx};
	endfunction

	task automatic cpu_access(input logic we, input logic [ADDR_W-1:0] addr,
		input word_t wdata, output word_t rdata);
		cpu_valid <= 1'b1;
		cpu_we <= we;
		cpu_addr <= addr;
		cpu_wdata <= wdata;
		do @(posedge clk); while (!cpu_ready);	// accepted on this edge
		cpu_valid <= 1'b0;
		do @(posedge clk); while (!cpu_rsp_valid);
		rdata = cpu_rdata;
		n_acc++;
	endtask

	// valid stays high, next request queued right at acceptance
	task automatic burst(input int n);
		for (int k = 0; k < n; k++) begin
			cpu_valid <= 1'b1;
			cpu_we <= ~k[0];	// write then read back
			cpu_addr <= (k % 3 == 2) ? 16'hc000 : ram_addr(RAM_AW'(300 + k / 2));
			cpu_wdata <= word_t'($urandom);
			do @(posedge clk); while (!cpu_ready);
			n_acc++;
		end
		cpu_valid <= 1'b0;
		do @(posedge clk); while (!cpu_rsp_valid);
	endtask

	task automatic ext_pulse();
		ext_int <= 1'b1;
		repeat (3) @(posedge clk);
		ext_int <= 1'b0;
		@(posedge clk);
	endtask

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------
	initial begin
		word_t rd;
		logic [RAM_AW-1:0] idx_list [32];
		logic [RAM_AW-1:0] src;
		word_t len;
		void'($urandom(32'hc28cf045));
		reset = 1'b1;
		cpu_valid = 1'b0;
		cpu_we = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		ext_int = 1'b0;
		end_chk = 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		for (int i = 0; i < 32; i++) begin	// random ram writes
			idx_list[i] = RAM_AW'($urandom);
			cpu_access(1'b1, ram_addr(idx_list[i]), word_t'($urandom), rd);
		end
		for (int i = 0; i < 8; i++)	// unmapped, regions 2 and 3
			cpu_access(i[0], {2'(2 + i % 2), 14'($urandom)}, word_t'($urandom), rd);
		for (int i = 0; i < 32; i++)
			cpu_access(1'b0, ram_addr(idx_list[i]), '0, rd);
		// interrupt set/clear and levels
		cpu_access(1'b1, reg_addr(REG_INTENA), 16'hc007, rd);
		cpu_access(1'b0, reg_addr(REG_INTENA), '0, rd);
		cpu_access(1'b1, reg_addr(REG_INTENA), 16'h0001, rd);
		cpu_access(1'b1, reg_addr(REG_INTENA), 16'h8007, rd);
		cpu_access(1'b1, reg_addr(REG_INTREQ), 16'h8001, rd);	// soft, level 1
		ext_pulse();	// level 6
		cpu_access(1'b0, reg_addr(REG_INTREQ), '0, rd);
		cpu_access(1'b1, reg_addr(REG_INTREQ), 16'h0004, rd);
		// block copy with cpu traffic beside it
		src = RAM_AW'(100 + $urandom % 50);
		len = word_t'(1 + $urandom % MAX_LEN);
		for (int i = 0; i < int'(len); i++)
			cpu_access(1'b1, ram_addr(src + RAM_AW'(i)), word_t'($urandom), rd);
		cpu_access(1'b1, reg_addr(REG_BLTSRC), word_t'(src), rd);
		cpu_access(1'b1, reg_addr(REG_BLTDST), 16'd600, rd);
		cpu_access(1'b1, reg_addr(REG_BLTLEN), len, rd);
		cpu_access(1'b1, reg_addr(REG_BLTLEN), 16'd5, rd);	// ignored while busy
		while (copy_busy) begin
			cpu_access(1'b1, ram_addr(RAM_AW'(300 + $urandom % 100)), word_t'($urandom), rd);
			cpu_access(1'b0, cpu_addr, '0, rd);
			cpu_access(1'b0, reg_addr(REG_STATUS), '0, rd);
		end
		cpu_access(1'b0, reg_addr(REG_STATUS), '0, rd);
		cpu_access(1'b0, reg_addr(REG_BLTSRC), '0, rd);
		cpu_access(1'b0, reg_addr(REG_BLTDST), '0, rd);
		cpu_access(1'b0, reg_addr(REG_BLTLEN), '0, rd);
		for (int i = 0; i < int'(len); i++)
			cpu_access(1'b0, ram_addr(RAM_AW'(600 + i)), '0, rd);
		cpu_access(1'b1, reg_addr(REG_BLTLEN), 16'd0, rd);	// zero length, no copy
		cpu_access(1'b0, reg_addr(REG_STATUS), '0, rd);
		cpu_access(1'b0, reg_addr(REG_INTREQ), '0, rd);	// blit bit now set
		cpu_access(1'b1, reg_addr(REG_INTENA), 16'h4000, rd);	// master off, level 0
		burst(8);
		end_chk <= 1'b1;
		repeat (3) @(posedge clk);
		$display("closing: %0d errors over %0d accesses", err_cnt, n_acc);
		if (err_cnt == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
